// File: project.f
+incdir+design
design/nes_glue_pkg.sv
design/host_reg_decode.sv
design/bus_sequencer.sv
design/joypad_shifter.sv
design/nes_glue_top.sv
verif/nes_glue_checker.sv
verif/nes_glue_tb.sv

// File: Makefile
# Verilator build and run for the nes glue testbench

TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = nes_glue_tb
FILELIST = project.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(wildcard design/*.sv design/*.svh verif/*.sv)
PASS_MSG = Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the trace file is read relative to the project root
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/nes_glue_trace.txt
# H addr data | B hostbyte sdbyte | S byte | L done | P pad1 pad2
# J port expbits | M lw cr pr nw lref memslot | R cycles expcount (all hex)
H 37 a5
S 3c
B 5a c3
H 35 01
H 35 00
H 40 11
H 41 80
H 37 0f
P 02 01
J 0 13
J 1 81
H 40 00
P 40 00
J 0 40
L 0
R 19 0
L 1
R 19 5
R 32 a
M 1 0 0 1 0 1
M 0 0 0 0 0 1
M 0 1 1 0 0 1
M 0 1 1 0 0 0
M 0 0 0 0 1 0
M 1 0 0 0 1 1
L 0
R a 0

// File: verif/nes_glue_tb.sv
// --------------------------------------------------
// trace driven testbench for nes_glue_top
// reference model, lfsr background data, check task
// --------------------------------------------------
`timescale 1ns/1ps
`include "nes_glue_settings.svh"

module nes_glue_tb;

  logic clk = 1'b0;
  logic sys_resetn;
  nes_glue_pkg::byte_t host_addr, host_data, sd_data, loader_wdata, nes_wdata;
  logic host_write, sd_valid, loader_done, loader_write, loader_refresh;
  logic cpu_read, ppu_read, nes_write, joypad_strobe;
  nes_glue_pkg::mem_addr_t loader_addr, nes_addr, mem_addr;
  logic [1:0] joypad_clock, joypad_data;
  nes_glue_pkg::btn_t pad_btn1, pad_btn2;
  nes_glue_pkg::byte_t loader_byte, mem_din;
  logic loader_strobe, loader_reset, run_nes;
  logic mem_read_a, mem_read_b, mem_write, mem_refresh;

  int errors = 0;
  int checks = 0;
  logic [31:0] lfsr_state = 32'h85ed;
  // reference model state
  nes_glue_pkg::btn_t m_btn [2];
  nes_glue_pkg::btn_t m_pad [2];
  logic m_conf = 1'b0;

  nes_glue_top dut (.*);

  always #2 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #1;  // drive point
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic write_host_reg(input logic [7:0] addr, input logic [7:0] data,
                                input logic with_sd, input logic [7:0] sdb);
    logic exp_strobe;
    host_addr  = addr;
    host_data  = data;
    host_write = 1'b1;
    sd_data    = sdb;
    sd_valid   = with_sd;
    #1;
    exp_strobe = with_sd || (addr == `HOST_ADDR_DATA);
    check("loader_strobe", 32'(exp_strobe), 32'(loader_strobe));
    if (exp_strobe)
      check("loader_byte", 32'(with_sd ? sdb : data), 32'(loader_byte));  // sd wins
    if (addr == `HOST_ADDR_CONF) m_conf = data[`CONF_RESET_BIT];
    if (addr == `HOST_ADDR_BTN1) m_btn[0] = data;
    if (addr == `HOST_ADDR_BTN2) m_btn[1] = data;
    step();
    host_write = 1'b0;
    sd_valid   = 1'b0;
    check("loader_reset", 32'(m_conf), 32'(loader_reset));
  endtask

  task automatic send_sd_byte(input logic [7:0] sdb);
    sd_data  = sdb;
    sd_valid = 1'b1;
    #1;
    check("sd strobe", 32'd1, 32'(loader_strobe));
    check("sd byte", 32'(sdb), 32'(loader_byte));
    step();
    sd_valid = 1'b0;
  endtask

  task automatic read_joypad_port(input int port, input logic [7:0] exp);
    logic [7:0] word;
    logic       other_bit;
    word      = m_btn[port] | m_pad[port];
    other_bit = m_btn[1-port][0] | m_pad[1-port][0];
    check("joypad model", 32'(exp), 32'(word));
    joypad_strobe = 1'b1;
    step();
    joypad_strobe = 1'b0;
    for (int i = 0; i < 8; i++) begin
      check($sformatf("joypad%0d bit%0d", port, i), 32'(exp[i]), 32'(joypad_data[port]));
      check("joypad other port", 32'(other_bit), 32'(joypad_data[1-port]));
      joypad_clock[port] = 1'b1;
      step();
      joypad_clock[port] = 1'b0;
      step();  // falling edge shifts here
    end
    check("joypad zero fill", 32'd0, 32'(joypad_data[port]));
  endtask

  task automatic wait_run_nes();
    int n;
    n = 0;
    step();
    while (run_nes !== 1'b1) begin
      step();
      n++;
      if (n > 20) begin
        $display("timeout while waiting for a run_nes pulse");
        $display("Simulation failed");
        $finish;
      end
    end
  endtask

  task automatic drive_mem_request(input logic lw, input logic cr, input logic pr,
                                   input logic nw, input logic lref, input logic slot);
    logic exp_refresh;
    wait_run_nes();
    step();               // memory phase
    if (!slot) step();    // one phase later
    loader_addr    = nes_glue_pkg::mem_addr_t'(take_bits(`NES_ADDR_W));
    loader_wdata   = 8'(take_bits(8));
    nes_addr       = nes_glue_pkg::mem_addr_t'(take_bits(`NES_ADDR_W));
    nes_wdata      = 8'(take_bits(8));
    loader_write   = lw;
    loader_refresh = lref;
    cpu_read       = cr;
    ppu_read       = pr;
    nes_write      = nw;
    #1;
    exp_refresh = (slot && !cr && !pr && !nw && !lw) || (lref && !lw);
    check("mem_write", 32'(lw || (nw && slot)), 32'(mem_write));
    check("mem_read_a", 32'(cr && slot), 32'(mem_read_a));
    check("mem_read_b", 32'(pr && slot), 32'(mem_read_b));
    check("mem_refresh", 32'(exp_refresh), 32'(mem_refresh));
    check("mem_addr", 32'(lw ? loader_addr : nes_addr), 32'(mem_addr));
    check("mem_din", 32'(lw ? loader_wdata : nes_wdata), 32'(mem_din));
    step();
    {loader_write, loader_refresh, cpu_read, ppu_read, nes_write} = '0;
  endtask

  task automatic count_runs(input int cycles, input int exp);
    int cnt;
    cnt = 0;
    for (int i = 0; i < cycles; i++) begin
      step();
      if (run_nes) cnt++;
    end
    check("run_nes count", 32'(exp), 32'(cnt));
  endtask

  initial begin
    int fd, code;
    logic [7:0] cmd;
    logic [31:0] a, b, c, d, e, f;
    string line;
    sys_resetn = 1'b0;
    {host_addr, host_data, sd_data, loader_wdata, nes_wdata} = '0;
    {host_write, sd_valid, loader_done, loader_write, loader_refresh} = '0;
    {cpu_read, ppu_read, nes_write, joypad_strobe} = '0;
    loader_addr  = '0;
    nes_addr     = '0;
    joypad_clock = '0;
    pad_btn1     = '0;
    pad_btn2     = '0;
    m_btn[0] = '0;
    m_btn[1] = '0;
    m_pad[0] = '0;
    m_pad[1] = '0;
    repeat (16) @(posedge clk);
    #1;
    check("loader_reset in reset", 32'd1, 32'(loader_reset));
    sys_resetn = 1'b1;
    step();
    check("run_nes after reset", 32'd0, 32'(run_nes));
    check("mem strobes after reset", 32'd0,
          32'({mem_read_a, mem_read_b, mem_write, mem_refresh}));
    check("loader_strobe after reset", 32'd0, 32'(loader_strobe));
    check("joypad_data after reset", 32'd0, 32'(joypad_data));
    fd = $fopen("verif/nes_glue_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1) break;
        case (cmd)
          "#": code = $fgets(line, fd);  // comment line
          "H": begin
            code = $fscanf(fd, "%h %h", a, b);
            write_host_reg(a[7:0], b[7:0], 1'b0, 8'h00);
          end
          "B": begin  // host data write and sd byte together
            code = $fscanf(fd, "%h %h", a, b);
            write_host_reg(`HOST_ADDR_DATA, a[7:0], 1'b1, b[7:0]);
          end
          "S": begin
            code = $fscanf(fd, "%h", a);
            send_sd_byte(a[7:0]);
          end
          "L": begin
            code = $fscanf(fd, "%h", a);
            loader_done = a[0];
          end
          "P": begin
            code = $fscanf(fd, "%h %h", a, b);
            pad_btn1 = a[7:0];
            pad_btn2 = b[7:0];
            m_pad[0] = a[7:0];
            m_pad[1] = b[7:0];
          end
          "J": begin
            code = $fscanf(fd, "%h %h", a, b);
            read_joypad_port(int'(a[0]), b[7:0]);
          end
          "M": begin
            code = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
            drive_mem_request(a[0], b[0], c[0], d[0], e[0], f[0]);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            count_runs(int'(a), int'(b));
          end
          default: begin
            $display("unknown command in the trace file");
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verif/nes_glue_checker.sv
// --------------------------------------------------
// concurrent assertions on the bus sequencer
// run strobe spacing and memory arbitration rules
// --------------------------------------------------
`timescale 1ns/1ps

module nes_glue_checker (
  input logic  clk,
  input logic  sys_resetn,
  input logic  loader_done,
  input logic  run_nes,
  input logic  mem_write,
  input logic  mem_refresh
);

  // no pulse in the four cycles before a pulse
  a_run_spacing: assert property (@(posedge clk) disable iff (!sys_resetn)
    run_nes |-> !$past(run_nes, 1) && !$past(run_nes, 2)
             && !$past(run_nes, 3) && !$past(run_nes, 4))
    else $error("run_nes pulses closer than 5 cycles");

  a_run_period: assert property (@(posedge clk) disable iff (!sys_resetn)
    ($past(run_nes, 5) && loader_done) |-> run_nes)
    else $error("run_nes missing 5 cycles after last pulse");

  a_write_xor_refresh: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(mem_write && mem_refresh)) else $error("write and refresh together");

endmodule

bind bus_sequencer nes_glue_checker u_checker (
  .clk(clk), .sys_resetn(sys_resetn), .loader_done(loader_done),
  .run_nes(run_nes), .mem_write(mem_write), .mem_refresh(mem_refresh)
);

// File: design/nes_glue_top.sv
// --------------------------------------------------
// nes glue top level
// host decode, bus sequencer and joypad shifter
// --------------------------------------------------
`timescale 1ns/1ps
`include "nes_glue_settings.svh"

module nes_glue_top (
  input  logic                     clk,
  input  logic                     sys_resetn,
  // host and sd card
  input  nes_glue_pkg::byte_t      host_addr,
  input  nes_glue_pkg::byte_t      host_data,
  input  logic                     host_write,
  input  nes_glue_pkg::byte_t      sd_data,
  input  logic                     sd_valid,
  // external game loader
  input  logic                     loader_done,
  input  nes_glue_pkg::mem_addr_t  loader_addr,
  input  nes_glue_pkg::byte_t      loader_wdata,
  input  logic                     loader_write,
  input  logic                     loader_refresh,
  // nes core memory requests
  input  logic                     cpu_read,
  input  logic                     ppu_read,
  input  logic                     nes_write,
  input  nes_glue_pkg::mem_addr_t  nes_addr,
  input  nes_glue_pkg::byte_t      nes_wdata,
  // joypads
  input  logic                     joypad_strobe,
  input  logic [1:0]               joypad_clock,
  input  nes_glue_pkg::btn_t       pad_btn1,
  input  nes_glue_pkg::btn_t       pad_btn2,
  output nes_glue_pkg::byte_t      loader_byte,
  output logic                     loader_strobe,
  output logic                     loader_reset,
  output logic                     run_nes,
  output logic                     mem_read_a,
  output logic                     mem_read_b,
  output logic                     mem_write,
  output logic                     mem_refresh,
  output nes_glue_pkg::mem_addr_t  mem_addr,
  output nes_glue_pkg::byte_t      mem_din,
  output logic [1:0]               joypad_data
);

  nes_glue_pkg::btn_t host_btn1;  // host register to joypad port 1
  nes_glue_pkg::btn_t host_btn2;

  host_reg_decode u_decode (
    .clk(clk), .sys_resetn(sys_resetn),
    .host_addr(host_addr), .host_data(host_data), .host_write(host_write),
    .sd_data(sd_data), .sd_valid(sd_valid),
    .loader_byte(loader_byte), .loader_strobe(loader_strobe),
    .loader_reset(loader_reset),
    .host_btn1(host_btn1), .host_btn2(host_btn2)
  );

  bus_sequencer u_seq (
    .clk(clk), .sys_resetn(sys_resetn), .loader_done(loader_done),
    .loader_addr(loader_addr), .loader_wdata(loader_wdata),
    .loader_write(loader_write), .loader_refresh(loader_refresh),
    .cpu_read(cpu_read), .ppu_read(ppu_read), .nes_write(nes_write),
    .nes_addr(nes_addr), .nes_wdata(nes_wdata),
    .run_nes(run_nes), .mem_read_a(mem_read_a), .mem_read_b(mem_read_b),
    .mem_write(mem_write), .mem_refresh(mem_refresh),
    .mem_addr(mem_addr), .mem_din(mem_din)
  );

  joypad_shifter u_joypad (
    .clk(clk), .sys_resetn(sys_resetn),
    .joypad_strobe(joypad_strobe), .joypad_clock(joypad_clock),
    .host_btn1(host_btn1), .host_btn2(host_btn2),
    .pad_btn1(pad_btn1), .pad_btn2(pad_btn2),
    .joypad_data(joypad_data)
  );

endmodule

// File: design/joypad_shifter.sv
// --------------------------------------------------
// joypad shifter
// two latching shift registers feeding the serial
// joypad inputs of the nes core
// --------------------------------------------------
`timescale 1ns/1ps
`include "nes_glue_settings.svh"

module joypad_shifter (
  input  logic                clk,
  input  logic                sys_resetn,
  input  logic                joypad_strobe,
  input  logic [1:0]          joypad_clock,
  input  nes_glue_pkg::btn_t  host_btn1,
  input  nes_glue_pkg::btn_t  host_btn2,
  input  nes_glue_pkg::btn_t  pad_btn1,
  input  nes_glue_pkg::btn_t  pad_btn2,
  output logic [1:0]          joypad_data
);

  nes_glue_pkg::btn_t btn_load [2];  // word latched on strobe
  nes_glue_pkg::btn_t bits_q [2];    // shift register per port
  logic [1:0]         last_clk_q;
  logic [1:0]         clk_fall;

  // host buttons and controller buttons are merged
  assign btn_load[0] = host_btn1 | pad_btn1;
  assign btn_load[1] = host_btn2 | pad_btn2;

  // falling edge against last cycle's joypad clock
  assign clk_fall = last_clk_q & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      bits_q[0]  <= '0;
      bits_q[1]  <= '0;
      last_clk_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (joypad_strobe)
          bits_q[p] <= btn_load[p];
        // a shift in the same cycle takes precedence
        if (clk_fall[p])
          bits_q[p] <= {1'b0, bits_q[p][7:1]};  // lsb first, zero fill
      end
      last_clk_q <= joypad_clock;
    end
  end

  // port 2 on bit 1
  assign joypad_data = {bits_q[1][0], bits_q[0][0]};

endmodule

// File: design/bus_sequencer.sv
// --------------------------------------------------
// bus sequencer
// five phase counter, nes run strobe and the
// loader / nes arbitration of the memory port
// --------------------------------------------------
`timescale 1ns/1ps
`include "nes_glue_settings.svh"

module bus_sequencer (
  input  logic                     clk,
  input  logic                     sys_resetn,
  input  logic                     loader_done,
  input  nes_glue_pkg::mem_addr_t  loader_addr,
  input  nes_glue_pkg::byte_t      loader_wdata,
  input  logic                     loader_write,
  input  logic                     loader_refresh,
  input  logic                     cpu_read,
  input  logic                     ppu_read,
  input  logic                     nes_write,
  input  nes_glue_pkg::mem_addr_t  nes_addr,
  input  nes_glue_pkg::byte_t      nes_wdata,
  output logic                     run_nes,
  output logic                     mem_read_a,
  output logic                     mem_read_b,
  output logic                     mem_write,
  output logic                     mem_refresh,
  output nes_glue_pkg::mem_addr_t  mem_addr,
  output nes_glue_pkg::byte_t      mem_din
);

  localparam nes_glue_pkg::bus_phase_e LAST_PHASE =
    nes_glue_pkg::bus_phase_e'(`NES_PHASES - 1);
  localparam nes_glue_pkg::bus_phase_e RUN_PHASE =
    nes_glue_pkg::bus_phase_e'(`NES_RUN_PHASE);

  //  phase   | 0 mem | 1 act | 2 rw | 3 wait | 4 nes |
  //  the read issued on phase 0 is back by phase 4
  nes_glue_pkg::bus_phase_e phase_q;

  logic run_mem;
  logic nes_idle;    // no nes access pending
  logic loader_sel;  // loader owns addr and data

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase_q <= nes_glue_pkg::PH_MEM;
    end else if (phase_q == LAST_PHASE) begin
      phase_q <= nes_glue_pkg::PH_MEM;  // wrap after the nes phase
    end else begin
      phase_q <= nes_glue_pkg::bus_phase_e'(phase_q + 3'd1);
    end
  end

  // nothing runs until the rom is loaded
  assign run_mem = (phase_q == nes_glue_pkg::PH_MEM) && loader_done;
  assign run_nes = (phase_q == RUN_PHASE) && loader_done;

  assign nes_idle   = !cpu_read && !ppu_read && !nes_write;
  assign loader_sel = loader_write;

  // nes accesses only reach memory in the memory slot
  assign mem_read_a = cpu_read && run_mem;
  assign mem_read_b = ppu_read && run_mem;
  assign mem_write  = loader_sel || (nes_write && run_mem);

  // refresh on an idle slot, or when the loader asks for one
  assign mem_refresh = (run_mem && nes_idle && !loader_sel)
                    || (loader_refresh && !loader_sel);

  // loader writes override the nes
  assign mem_addr = loader_sel ? loader_addr : nes_addr;
  assign mem_din  = loader_sel ? loader_wdata : nes_wdata;

endmodule

// File: design/host_reg_decode.sv
// --------------------------------------------------
// host register decode
// loader byte stream, loader reset, host buttons
// --------------------------------------------------
`timescale 1ns/1ps
`include "nes_glue_settings.svh"

module host_reg_decode (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  nes_glue_pkg::byte_t  host_addr,
  input  nes_glue_pkg::byte_t  host_data,
  input  logic                 host_write,
  input  nes_glue_pkg::byte_t  sd_data,
  input  logic                 sd_valid,
  output nes_glue_pkg::byte_t  loader_byte,
  output logic                 loader_strobe,
  output logic                 loader_reset,
  output nes_glue_pkg::btn_t   host_btn1,
  output nes_glue_pkg::btn_t   host_btn2
);

  logic wr_conf;
  logic wr_data;
  logic wr_btn1;
  logic wr_btn2;
  logic conf_reset_q;  // loader held in reset by host

  // address match, qualified by the write strobe
  assign wr_conf = host_write && (host_addr == `HOST_ADDR_CONF);
  assign wr_data = host_write && (host_addr == `HOST_ADDR_DATA);
  assign wr_btn1 = host_write && (host_addr == `HOST_ADDR_BTN1);
  assign wr_btn2 = host_write && (host_addr == `HOST_ADDR_BTN2);

  // rom stream, sd card wins over the host
  assign loader_byte   = sd_valid ? sd_data : host_data;
  assign loader_strobe = sd_valid || wr_data;

  assign loader_reset = !sys_resetn || conf_reset_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reset_q <= 1'b0;
      host_btn1    <= '0;
      host_btn2    <= '0;
    end else begin
      if (wr_conf)
        conf_reset_q <= host_data[`CONF_RESET_BIT];  // other bits unused
      if (wr_btn1)
        host_btn1 <= host_data;
      if (wr_btn2)
        host_btn2 <= host_data;
    end
  end

endmodule

// File: design/nes_glue_pkg.sv
// --------------------------------------------------
// types shared by the nes glue modules
// bytes, memory addresses, button words, bus phases
// --------------------------------------------------
`include "nes_glue_settings.svh"

package nes_glue_pkg;

  // one data byte on the host, sd and memory buses
  typedef logic [7:0] byte_t;

  // memory address into the sdram space
  typedef logic [`NES_ADDR_W-1:0] mem_addr_t;

  // button word, bit order R L D U START SELECT B A
  typedef logic [7:0] btn_t;

  // phases of one nes step
  typedef enum logic [2:0] {
    PH_MEM  = 3'd0,  // memory command issued
    PH_ACT  = 3'd1,  // row activate
    PH_RW   = 3'd2,  // read or write
    PH_WAIT = 3'd3,
    PH_NES  = 3'd4   // nes core runs, read data valid
  } bus_phase_e;

endpackage

// File: design/nes_glue_settings.svh
// --------------------------------------------------
// fixed constants of the nes glue logic
// memory address width, bus phase timing and the
// host register map of the uart demux
// --------------------------------------------------
`ifndef NES_GLUE_SETTINGS_SVH
`define NES_GLUE_SETTINGS_SVH

// memory side
`define NES_ADDR_W      22      // 4 MB sdram space

// one nes step is five clk cycles, memory slot on phase 0
`define NES_PHASES      5
`define NES_RUN_PHASE   4       // nes core clock enable

// host register addresses
`define HOST_ADDR_CONF  8'h35   // loader configuration
`define HOST_ADDR_DATA  8'h37   // rom byte stream
`define HOST_ADDR_BTN1  8'h40   // host buttons, port 1
`define HOST_ADDR_BTN2  8'h41   // host buttons, port 2

// bit of the configuration register that holds the loader in reset
`define CONF_RESET_BIT  0

`endif
